/* logic/rv_mem_pkg.sv */
// RV64 memory instruction encodings: opcodes, funct3 values, access sizes, formats, exception codes
`default_nettype none

package rv_mem_pkg;

  // Integer register width
  localparam int XLEN_W = 64;

  // ----------------------------------------------------------------------
  // Major opcodes and funct3
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // Zero-extending loads
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_LWU = 3'b110;
  // Widest store, anything above is reserved
  localparam logic [2:0] F3_SD  = 3'b011;

  // Access size, same coding as funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  // ----------------------------------------------------------------------
  // Instruction formats
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Store immediate is split around rs2/rs1
  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } s_fmt_t;

  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } mem_inst_u;

  // mcause values
  localparam logic [3:0] EXC_ILLEGAL_INST   = 4'd2;
  localparam logic [3:0] EXC_LOAD_MISALIGN  = 4'd4;
  localparam logic [3:0] EXC_STORE_MISALIGN = 4'd6;

endpackage

`default_nettype wire

/* logic/lsu_pipe_pkg.sv */
// LSU pipeline widths and the structs passed between stages and to the cache and store queue
`default_nettype none

package lsu_pipe_pkg;

  localparam int TAG_W  = 6;
  localparam int RD_W   = 5;
  localparam int EXC_W  = 4;
  localparam int LINE_W = 128;
  localparam int LINE_B = LINE_W / 8;
  localparam int FWD_B  = 8;

  // Datapath doubleword
  typedef logic [63:0] dword_t;

  // Decoded control, no kind bit set means illegal
  typedef struct packed {
    logic       is_load;
    logic       is_store;
    logic [1:0] size;
    logic       is_signed;
  } pipe_ctrl_t;

  // ----------------------------------------------------------------------
  // External ports
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic             valid;
    logic [31:0]      inst;
    dword_t           rs1_data;
    logic [RD_W-1:0]  rd;
    logic [TAG_W-1:0] tag;
  } issue_t;

  typedef struct packed {
    logic   valid;
    dword_t addr;
  } l1d_req_t;

  typedef struct packed {
    logic [LINE_W-1:0] data;
  } l1d_resp_t;

  typedef struct packed {
    logic             valid;
    dword_t           addr;
    logic [FWD_B-1:0] mask;
  } fwd_req_t;

  typedef struct packed {
    logic [FWD_B-1:0] mask;
    dword_t           data;
  } fwd_resp_t;

  typedef struct packed {
    logic            valid;
    logic [RD_W-1:0] rd;
    dword_t          data;
  } wb_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic             except_valid;
    logic [EXC_W-1:0] except_code;
    dword_t           tval;
  } done_t;

  // ----------------------------------------------------------------------
  // Stage bundles
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic             valid;
    pipe_ctrl_t       ctrl;
    dword_t           addr;
    logic             except_valid;
    logic [EXC_W-1:0] except_code;
    dword_t           tval;
    logic [RD_W-1:0]  rd;
    logic [TAG_W-1:0] tag;
  } ex2_bundle_t;

  typedef struct packed {
    logic             valid;
    logic             is_load;
    logic             except_valid;
    logic [EXC_W-1:0] except_code;
    dword_t           tval;
    logic [RD_W-1:0]  rd;
    logic [TAG_W-1:0] tag;
    dword_t           data;
  } ex3_bundle_t;

endpackage

`default_nettype wire

/* logic/lsu_mem_decoder.sv */
// Load/store decoder: kind, size, sign and sign-extended offset from a 32-bit instruction
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_decoder (
  input  wire rv_mem_pkg::mem_inst_u    i_inst,
  output lsu_pipe_pkg::pipe_ctrl_t      o_ctrl,
  output logic [rv_mem_pkg::XLEN_W-1:0] o_offset
);

  logic [11:0] w_imm;
  logic [2:0]  w_funct3;

  // funct3 sits in the same bits for both formats
  assign w_funct3 = i_inst.i_fmt.funct3;

  always_comb begin
    o_ctrl = '0;
    w_imm  = i_inst.i_fmt.imm;
    case (i_inst.i_fmt.opcode)
      rv_mem_pkg::OPC_LOAD: begin
        o_ctrl.is_load   = 1'b1;
        o_ctrl.size      = w_funct3[1:0];
        o_ctrl.is_signed = !(w_funct3 inside {rv_mem_pkg::F3_LBU,
                                              rv_mem_pkg::F3_LHU,
                                              rv_mem_pkg::F3_LWU});
      end
      rv_mem_pkg::OPC_STORE: begin
        // Reserved store widths stay illegal
        o_ctrl.is_store = (w_funct3 <= rv_mem_pkg::F3_SD);
        o_ctrl.size     = w_funct3[1:0];
        w_imm           = {i_inst.s_fmt.imm_hi, i_inst.s_fmt.imm_lo};
      end
      default: begin
        o_ctrl = '0;
      end
    endcase
  end

  assign o_offset = {{(rv_mem_pkg::XLEN_W - 12){w_imm[11]}}, w_imm};

endmodule

`default_nettype wire

/* logic/lsu_addr_stage.sv */
// EX1 stage: operation register, address add, exception check, L1D line request, EX2 register
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_stage (
  input  wire                              i_clk,
  input  wire                              i_reset_n,
  input  wire                              i_flush,
  input  wire lsu_pipe_pkg::issue_t        i_issue,
  input  wire lsu_pipe_pkg::pipe_ctrl_t    i_ctrl,
  input  wire [rv_mem_pkg::XLEN_W-1:0]     i_offset,
  output lsu_pipe_pkg::l1d_req_t           o_l1d_req,
  output lsu_pipe_pkg::ex2_bundle_t        o_ex2
);

  lsu_pipe_pkg::issue_t           r_ex1_issue;
  lsu_pipe_pkg::pipe_ctrl_t       r_ex1_ctrl;
  logic [rv_mem_pkg::XLEN_W-1:0]  r_ex1_offset;
  logic [rv_mem_pkg::XLEN_W-1:0]  w_ex1_addr;
  logic                           w_ex1_misalign;
  logic                           w_ex1_illegal;
  logic                           w_ex1_except;
  logic [lsu_pipe_pkg::EXC_W-1:0] w_ex1_code;
  lsu_pipe_pkg::dword_t           w_ex1_tval;
  lsu_pipe_pkg::ex2_bundle_t      r_ex2;

  // ----------------------------------------------------------------------
  // EX1 register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
    end else begin
      r_ex1_issue       <= i_issue;
      r_ex1_issue.valid <= i_issue.valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_ctrl   <= i_ctrl;
    r_ex1_offset <= i_offset;
  end

  // ----------------------------------------------------------------------
  // Address and exceptions
  // ----------------------------------------------------------------------
  assign w_ex1_addr = r_ex1_issue.rs1_data + r_ex1_offset;

  always_comb begin
    case (rv_mem_pkg::size_e'(r_ex1_ctrl.size))
      rv_mem_pkg::SIZE_H: w_ex1_misalign = w_ex1_addr[0];
      rv_mem_pkg::SIZE_W: w_ex1_misalign = |w_ex1_addr[1:0];
      rv_mem_pkg::SIZE_D: w_ex1_misalign = |w_ex1_addr[2:0];
      default:            w_ex1_misalign = 1'b0;
    endcase
  end

  assign w_ex1_illegal = ~(r_ex1_ctrl.is_load | r_ex1_ctrl.is_store);
  assign w_ex1_except  = w_ex1_illegal | w_ex1_misalign;

  // Illegal wins over misalignment
  assign w_ex1_code = w_ex1_illegal      ? rv_mem_pkg::EXC_ILLEGAL_INST  :
                      r_ex1_ctrl.is_load ? rv_mem_pkg::EXC_LOAD_MISALIGN :
                                           rv_mem_pkg::EXC_STORE_MISALIGN;
  assign w_ex1_tval = w_ex1_illegal ? {32'h0, r_ex1_issue.inst} : w_ex1_addr;

  // Whole line, only for clean loads
  assign o_l1d_req.valid = r_ex1_issue.valid & r_ex1_ctrl.is_load & ~w_ex1_except;
  assign o_l1d_req.addr  = {w_ex1_addr[rv_mem_pkg::XLEN_W-1:$clog2(lsu_pipe_pkg::LINE_B)],
                            {$clog2(lsu_pipe_pkg::LINE_B){1'b0}}};

  // ----------------------------------------------------------------------
  // EX2 register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2 <= '0;
    end else begin
      r_ex2.valid        <= r_ex1_issue.valid & ~i_flush;
      r_ex2.ctrl         <= r_ex1_ctrl;
      r_ex2.addr         <= w_ex1_addr;
      r_ex2.except_valid <= w_ex1_except;
      r_ex2.except_code  <= w_ex1_code;
      r_ex2.tval         <= w_ex1_tval;
      r_ex2.rd           <= r_ex1_issue.rd;
      r_ex2.tag          <= r_ex1_issue.tag;
    end
  end

  assign o_ex2 = r_ex2;

endmodule

`default_nettype wire

/* logic/lsu_load_merge.sv */
// EX2 stage: store-queue forward query, byte merge over cache data, extension, EX3 register
`timescale 1ns/1ps
`default_nettype none

module lsu_load_merge (
  input  wire                              i_clk,
  input  wire                              i_reset_n,
  input  wire                              i_flush,
  input  wire lsu_pipe_pkg::ex2_bundle_t   i_ex2,
  input  wire lsu_pipe_pkg::l1d_resp_t     i_l1d_resp,
  output lsu_pipe_pkg::fwd_req_t           o_fwd_req,
  input  wire lsu_pipe_pkg::fwd_resp_t     i_fwd_resp,
  output lsu_pipe_pkg::ex3_bundle_t        o_ex3
);

  rv_mem_pkg::size_e                w_size;
  logic [2:0]                       w_byte_ofs;
  logic [lsu_pipe_pkg::FWD_B-1:0]   w_size_mask;
  lsu_pipe_pkg::dword_t             w_line_dw;
  lsu_pipe_pkg::dword_t             w_merged;
  lsu_pipe_pkg::dword_t             w_shifted;
  logic [rv_mem_pkg::XLEN_W-1:0]    w_ext;
  lsu_pipe_pkg::ex3_bundle_t        r_ex3;

  assign w_size     = rv_mem_pkg::size_e'(i_ex2.ctrl.size);
  assign w_byte_ofs = i_ex2.addr[2:0];

  always_comb begin
    case (w_size)
      rv_mem_pkg::SIZE_B: w_size_mask = 8'h01;
      rv_mem_pkg::SIZE_H: w_size_mask = 8'h03;
      rv_mem_pkg::SIZE_W: w_size_mask = 8'h0f;
      default:            w_size_mask = 8'hff;
    endcase
  end

  // ----------------------------------------------------------------------
  // Forward query
  // ----------------------------------------------------------------------
  assign o_fwd_req.valid = i_ex2.valid & i_ex2.ctrl.is_load & ~i_ex2.except_valid;
  assign o_fwd_req.addr  = {i_ex2.addr[63:3], 3'b000};
  assign o_fwd_req.mask  = w_size_mask << w_byte_ofs;

  // Doubleword of the line picked by address bit 3
  assign w_line_dw = i_l1d_resp.data[{i_ex2.addr[3], 6'd0} +: 64];

  // Forwarded bytes override cache bytes
  for (genvar b = 0; b < lsu_pipe_pkg::FWD_B; b++) begin : g_merge
    assign w_merged[b*8 +: 8] = i_fwd_resp.mask[b] ? i_fwd_resp.data[b*8 +: 8] :
                                                     w_line_dw[b*8 +: 8];
  end

  assign w_shifted = w_merged >> {w_byte_ofs, 3'b000};

  // ----------------------------------------------------------------------
  // Size extraction and extension
  // ----------------------------------------------------------------------
  always_comb begin
    case (w_size)
      rv_mem_pkg::SIZE_B: begin
        w_ext = {{(rv_mem_pkg::XLEN_W - 8){i_ex2.ctrl.is_signed & w_shifted[7]}},
                 w_shifted[7:0]};
      end
      rv_mem_pkg::SIZE_H: begin
        w_ext = {{(rv_mem_pkg::XLEN_W - 16){i_ex2.ctrl.is_signed & w_shifted[15]}},
                 w_shifted[15:0]};
      end
      rv_mem_pkg::SIZE_W: begin
        w_ext = {{(rv_mem_pkg::XLEN_W - 32){i_ex2.ctrl.is_signed & w_shifted[31]}},
                 w_shifted[31:0]};
      end
      default: begin
        w_ext = w_shifted;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // EX3 register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3 <= '0;
    end else begin
      r_ex3.valid        <= i_ex2.valid & ~i_flush;
      r_ex3.is_load      <= i_ex2.ctrl.is_load;
      r_ex3.except_valid <= i_ex2.except_valid;
      r_ex3.except_code  <= i_ex2.except_code;
      r_ex3.tval         <= i_ex2.tval;
      r_ex3.rd           <= i_ex2.rd;
      r_ex3.tag          <= i_ex2.tag;
      r_ex3.data         <= w_ext;
    end
  end

  assign o_ex3 = r_ex3;

endmodule

`default_nettype wire

/* logic/lsu_pipe_top.sv */
// LSU pipeline top: EX0 decode, EX1 and EX2 stage instances, EX3 writeback and done report
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_top (
  input  wire                            i_clk,
  input  wire                            i_reset_n,
  input  wire lsu_pipe_pkg::issue_t      i_issue,
  input  wire                            i_flush,
  output lsu_pipe_pkg::l1d_req_t         o_l1d_req,
  input  wire lsu_pipe_pkg::l1d_resp_t   i_l1d_resp,
  output lsu_pipe_pkg::fwd_req_t         o_fwd_req,
  input  wire lsu_pipe_pkg::fwd_resp_t   i_fwd_resp,
  output lsu_pipe_pkg::wb_t              o_wb,
  output lsu_pipe_pkg::done_t            o_done
);

  rv_mem_pkg::mem_inst_u          w_ex0_inst;
  lsu_pipe_pkg::pipe_ctrl_t       w_ex0_ctrl;
  logic [rv_mem_pkg::XLEN_W-1:0]  w_ex0_offset;
  lsu_pipe_pkg::ex2_bundle_t      w_ex2;
  lsu_pipe_pkg::ex3_bundle_t      w_ex3;

  // ----------------------------------------------------------------------
  // EX0 decode
  // ----------------------------------------------------------------------
  assign w_ex0_inst = i_issue.inst;

  lsu_mem_decoder u_decoder (
    .i_inst   (w_ex0_inst),
    .o_ctrl   (w_ex0_ctrl),
    .o_offset (w_ex0_offset)
  );

  // ----------------------------------------------------------------------
  // EX1 and EX2, flush kills whatever sits in EX0..EX2
  // ----------------------------------------------------------------------
  lsu_addr_stage u_addr_stage (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_issue   (i_issue),
    .i_ctrl    (w_ex0_ctrl),
    .i_offset  (w_ex0_offset),
    .o_l1d_req (o_l1d_req),
    .o_ex2     (w_ex2)
  );

  lsu_load_merge u_load_merge (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_flush    (i_flush),
    .i_ex2      (w_ex2),
    .i_l1d_resp (i_l1d_resp),
    .o_fwd_req  (o_fwd_req),
    .i_fwd_resp (i_fwd_resp),
    .o_ex3      (w_ex3)
  );

  // ----------------------------------------------------------------------
  // EX3 report
  // ----------------------------------------------------------------------
  // Every op completes, excepting ones included
  assign o_done.valid        = w_ex3.valid;
  assign o_done.tag          = w_ex3.tag;
  assign o_done.except_valid = w_ex3.except_valid;
  assign o_done.except_code  = w_ex3.except_code;
  assign o_done.tval         = w_ex3.tval;

  // No write to x0
  assign o_wb.valid = w_ex3.valid & w_ex3.is_load & ~w_ex3.except_valid &
                      (w_ex3.rd != '0);
  assign o_wb.rd    = w_ex3.rd;
  assign o_wb.data  = w_ex3.data;

endmodule

`default_nettype wire

/* bench/lsu_pipe_checker.sv */
// Concurrent assertions on the LSU pipeline outputs, bound into the pipeline top
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_checker (
  input wire                         i_clk,
  input wire                         i_reset_n,
  input wire                         i_flush,
  input wire lsu_pipe_pkg::wb_t      i_wb,
  input wire lsu_pipe_pkg::done_t    i_done,
  input wire lsu_pipe_pkg::l1d_req_t i_l1d_req,
  input wire lsu_pipe_pkg::fwd_req_t i_fwd_req
);

  // A clean load in EX2 that is not flushed reports a clean done next cycle
  fwd_then_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_fwd_req.valid && !i_flush) |=> (i_done.valid && !i_done.except_valid))
    else $error("clean load lost between EX2 and EX3");

  // Writeback only for a load that queried the store queue
  wb_after_fwd: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wb.valid |-> $past(i_fwd_req.valid))
    else $error("writeback without a load in EX2");

  // Line request moves on to the forward query of the same line
  l1d_then_fwd: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_l1d_req.valid && !i_flush) |=>
      (i_fwd_req.valid && (i_fwd_req.addr[63:4] == $past(i_l1d_req.addr[63:4]))))
    else $error("line request not followed by its forward query");

  // Pipeline is empty right after reset
  fwd_idle_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |=> !i_fwd_req.valid)
    else $error("forward query right after reset");

endmodule

bind lsu_pipe_top lsu_pipe_checker u_checker (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_flush   (i_flush),
  .i_wb      (o_wb),
  .i_done    (o_done),
  .i_l1d_req (o_l1d_req),
  .i_fwd_req (o_fwd_req)
);

`default_nettype wire

/* bench/lsu_pipe_tb.sv */
// LSU pipeline testbench: clock, reset, xorshift stimulus, memory and forward models, checks
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_tb;

  localparam int OPS_PER_TEST = 200;
  localparam int NUM_TESTS    = 6;
  localparam int CYCLE_LIMIT  = NUM_TESTS * OPS_PER_TEST + 50;

  // Expected state of one op as it moves down the model pipeline
  typedef struct packed {
    logic        valid;
    logic        is_load;
    logic        is_signed;
    logic [1:0]  size;
    logic        exc;
    logic [3:0]  code;
    logic [63:0] tval;
    logic [63:0] addr;
    logic [4:0]  rd;
    logic [5:0]  tag;
    logic [63:0] data;
  } exp_t;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_flush;
  lsu_pipe_pkg::issue_t     i_issue;
  lsu_pipe_pkg::l1d_req_t   o_l1d_req;
  lsu_pipe_pkg::l1d_resp_t  i_l1d_resp;
  lsu_pipe_pkg::fwd_req_t   o_fwd_req;
  lsu_pipe_pkg::fwd_resp_t  i_fwd_resp;
  lsu_pipe_pkg::wb_t        o_wb;
  lsu_pipe_pkg::done_t      o_done;

  exp_t        e1;
  exp_t        e2;
  exp_t        e3;
  logic [31:0] rng_state;
  logic [5:0]  next_tag;
  int          errors;
  int          checks;
  int          cycles;
  string       test_names [NUM_TESTS];

  lsu_pipe_top i_dut (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .i_flush    (i_flush),
    .o_l1d_req  (o_l1d_req),
    .i_l1d_resp (i_l1d_resp),
    .o_fwd_req  (o_fwd_req),
    .i_fwd_resp (i_fwd_resp),
    .o_wb       (o_wb),
    .o_done     (o_done)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // Random numbers and models
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [7:0] mem_byte(input logic [63:0] a);
    return (a[7:0] ^ 8'h5a) + {4'h0, a[11:8]};
  endfunction

  function automatic logic [127:0] mem_line(input logic [63:0] addr);
    logic [127:0] line;
    for (int i = 0; i < 16; i++) begin
      line[i*8 +: 8] = mem_byte(addr + 64'(i));
    end
    return line;
  endfunction

  // Reference decode, address and exception rules
  function automatic exp_t model_issue(input lsu_pipe_pkg::issue_t iss);
    exp_t        e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        legal;
    logic        mis;
    e = '0;
    opc = iss.inst[6:0];
    f3 = iss.inst[14:12];
    e.valid = iss.valid;
    e.is_load = (opc == rv_mem_pkg::OPC_LOAD);
    legal = e.is_load || (opc == rv_mem_pkg::OPC_STORE && !f3[2]);
    imm = e.is_load ? iss.inst[31:20] : {iss.inst[31:25], iss.inst[11:7]};
    e.addr = iss.rs1_data + {{52{imm[11]}}, imm};
    e.size = f3[1:0];
    e.is_signed = !f3[2];
    case (e.size)
      2'd0: mis = 1'b0;
      2'd1: mis = e.addr[0];
      2'd2: mis = |e.addr[1:0];
      default: mis = |e.addr[2:0];
    endcase
    e.tval = e.addr;
    if (!legal) begin
      e.exc = 1'b1;
      e.code = 4'd2;
      e.tval = {32'h0, iss.inst};
    end else if (mis) begin
      e.exc = 1'b1;
      e.code = e.is_load ? 4'd4 : 4'd6;
    end
    e.rd = iss.rd;
    e.tag = iss.tag;
    return e;
  endfunction

  // Load result from memory bytes with forwarded bytes on top
  function automatic logic [63:0] model_data(input exp_t e, input logic [7:0] fmask,
                                             input logic [63:0] fdata);
    logic [63:0] dw;
    logic [63:0] base;
    logic [63:0] sh;
    base = {e.addr[63:3], 3'b000};
    for (int b = 0; b < 8; b++) begin
      dw[b*8 +: 8] = fmask[b] ? fdata[b*8 +: 8] : mem_byte(base + 64'(b));
    end
    sh = dw >> (8 * e.addr[2:0]);
    case (e.size)
      2'd0: return {{56{e.is_signed & sh[7]}}, sh[7:0]};
      2'd1: return {{48{e.is_signed & sh[15]}}, sh[15:0]};
      2'd2: return {{32{e.is_signed & sh[31]}}, sh[31:0]};
      default: return sh;
    endcase
  endfunction

  // Bytes of its doubleword that an aligned access touches
  function automatic logic [7:0] access_mask(input exp_t e);
    logic [15:0] m;
    m = ((16'd1 << (16'd1 << e.size)) - 16'd1) << e.addr[2:0];
    return m[7:0];
  endfunction

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_outputs();
    logic wb_exp;
    logic l1d_exp;
    logic fwd_exp;
    wb_exp = e3.valid && e3.is_load && !e3.exc && (e3.rd != 5'd0);
    l1d_exp = e1.valid && e1.is_load && !e1.exc;
    fwd_exp = e2.valid && e2.is_load && !e2.exc;
    if (o_done.valid !== e3.valid) begin
      errors++;
      if (e3.valid) begin
        $display("Missing done for op with tag %h", e3.tag);
      end else begin
        $display("Unexpected done with tag %h", o_done.tag);
      end
    end else if (e3.valid) begin
      compare("o_done.tag", 64'(o_done.tag), 64'(e3.tag));
      compare("o_done.except_valid", 64'(o_done.except_valid), 64'(e3.exc));
      if (e3.exc) begin
        compare("o_done.except_code", 64'(o_done.except_code), 64'(e3.code));
      end
      compare("o_done.tval", o_done.tval, e3.tval);
    end
    compare("o_wb.valid", 64'(o_wb.valid), 64'(wb_exp));
    if (wb_exp && o_wb.valid) begin
      compare("o_wb.rd", 64'(o_wb.rd), 64'(e3.rd));
      compare("o_wb.data", o_wb.data, e3.data);
    end
    // Cache request from EX1, forward query from EX2
    compare("o_l1d_req.valid", 64'(o_l1d_req.valid), 64'(l1d_exp));
    if (l1d_exp) begin
      compare("o_l1d_req.addr", o_l1d_req.addr, e1.addr & ~64'hf);
    end
    compare("o_fwd_req.valid", 64'(o_fwd_req.valid), 64'(fwd_exp));
    if (fwd_exp) begin
      compare("o_fwd_req.addr", o_fwd_req.addr, e2.addr & ~64'h7);
      compare("o_fwd_req.mask", 64'(o_fwd_req.mask), 64'(access_mask(e2)));
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic make_op(input int kind, output lsu_pipe_pkg::issue_t iss,
                         output logic fl, output logic [7:0] fm);
    rv_mem_pkg::mem_inst_u inst;
    logic [31:0] raw;
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [63:0] base;
    logic [63:0] low_mask;
    logic        is_store;
    logic        misalign;
    r = next_rand();
    raw = next_rand();
    inst = raw;
    imm = r[31:20];
    fl = (kind == 5) && (r[9:8] == 2'b00);
    fm = (kind == 1 || kind == 5) ? 8'(next_rand()) : 8'h00;
    is_store = (kind >= 2) && r[3];
    misalign = (kind == 2) || ((kind >= 4) && r[4]);
    f3 = 3'(r[18:16] % 7);
    if (is_store || misalign) begin
      f3 = {1'b0, f3[1:0]};
    end
    if (misalign && f3[1:0] == 2'd0) begin
      f3[1:0] = 2'd1 + 2'(r[5]);
    end
    low_mask = (64'd1 << f3[1:0]) - 64'd1;
    base = {next_rand(), next_rand()} & ~low_mask;
    if (misalign) begin
      base = base | ((64'(r[7:5]) & low_mask) | 64'd1);
    end
    if (is_store) begin
      inst.s_fmt.opcode = rv_mem_pkg::OPC_STORE;
      inst.s_fmt.funct3 = f3;
      inst.s_fmt.imm_hi = imm[11:5];
      inst.s_fmt.imm_lo = imm[4:0];
    end else begin
      inst.i_fmt.opcode = rv_mem_pkg::OPC_LOAD;
      inst.i_fmt.funct3 = f3;
      inst.i_fmt.imm = imm;
    end
    if (kind == 3) begin
      if (r[10]) begin
        inst.s_fmt.opcode = rv_mem_pkg::OPC_STORE;
        inst.s_fmt.funct3 = {1'b1, r[12:11]};
      end else begin
        // Random opcode, steered off the two memory opcodes
        inst.i_fmt.opcode = raw[6:0];
        if (raw[6:0] == rv_mem_pkg::OPC_LOAD || raw[6:0] == rv_mem_pkg::OPC_STORE) begin
          inst.i_fmt.opcode = 7'b0110011;
        end
      end
    end
    iss.valid = 1'b1;
    iss.inst = inst;
    iss.rs1_data = base - {{52{imm[11]}}, imm};
    iss.rd = (kind == 4) ? 5'd0 : 5'(next_rand());
    iss.tag = next_tag;
    next_tag = next_tag + 6'd1;
  endtask

  // One clock edge: check EX3, advance the model, drive the next inputs
  task automatic step(input int kind, input logic issue_on);
    lsu_pipe_pkg::issue_t iss;
    logic                 fl;
    logic [7:0]           fm;
    @(posedge i_clk);
    compare_outputs();
    if (e2.valid) begin
      e2.data = model_data(e2, i_fwd_resp.mask, i_fwd_resp.data);
    end
    e3 = e2;
    e3.valid = e2.valid & ~i_flush;
    e2 = e1;
    e2.valid = e1.valid & ~i_flush;
    e1 = model_issue(i_issue);
    e1.valid = e1.valid & ~i_flush;
    iss = '0;
    fl = 1'b0;
    fm = 8'h00;
    if (issue_on) begin
      make_op(kind, iss, fl, fm);
    end
    i_issue <= iss;
    i_flush <= fl;
    i_fwd_resp.mask <= fm;
    i_fwd_resp.data <= {next_rand(), next_rand()};
    i_l1d_resp.data <= mem_line(o_l1d_req.addr);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence and timeout
  // ----------------------------------------------------------------------
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int start_errors;
    test_names = '{"aligned loads", "forwarded loads", "misaligned access",
                   "illegal instructions", "x0 and stores", "random flush"};
    i_reset_n = 1'b0;
    i_flush = 1'b0;
    i_issue = '0;
    i_l1d_resp = '0;
    i_fwd_resp = '0;
    e1 = '0;
    e2 = '0;
    e3 = '0;
    rng_state = 32'hb5ab;
    next_tag = '0;
    errors = 0;
    checks = 0;
    cycles = 0;
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      start_errors = errors;
      repeat (OPS_PER_TEST) step(t, 1'b1);
      repeat (3) step(t, 1'b0);
      $display("Test %0d (%s): %0d errors", t + 1, test_names[t], errors - start_errors);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
logic/rv_mem_pkg.sv
logic/lsu_pipe_pkg.sv
logic/lsu_mem_decoder.sv
logic/lsu_addr_stage.sv
logic/lsu_load_merge.sv
logic/lsu_pipe_top.sv
bench/lsu_pipe_checker.sv
bench/lsu_pipe_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module lsu_pipe_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vlsu_pipe_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module lsu_pipe_tb
	verilator --lint-only -Wall logic/rv_mem_pkg.sv logic/lsu_pipe_pkg.sv \
		logic/lsu_mem_decoder.sv logic/lsu_addr_stage.sv logic/lsu_load_merge.sv \
		logic/lsu_pipe_top.sv --top-module lsu_pipe_top

clean:
	rm -rf obj_dir
